// File: logic/usb_rx_pkg.sv
package usb_rx_pkg;

  typedef logic [7:0]  usb_byte_t;
  typedef logic [3:0]  usb_pid_t;
  typedef logic [6:0]  usb_addr_t;
  typedef logic [3:0]  usb_endp_t;
  typedef logic [15:0] crc16_t;
  typedef logic [4:0]  crc5_t;
  typedef logic [1:0]  line_state_t;

  localparam line_state_t LS_SE0 = 2'b00;

  // Good-packet residual, register held LSB first (0x800D in spec bit order)
  localparam crc16_t CRC16_RESIDUAL = 16'hB001;

  // PID codes as carried in the low nibble of the PID byte
  localparam usb_pid_t PID_OUT   = 4'b0001;
  localparam usb_pid_t PID_IN    = 4'b1001;
  localparam usb_pid_t PID_SOF   = 4'b0101;
  localparam usb_pid_t PID_SETUP = 4'b1101;
  localparam usb_pid_t PID_PING  = 4'b0100;
  localparam usb_pid_t PID_NAK   = 4'b1010;

  // PID[1:0] type field
  localparam logic [1:0] PID_TYPE_SPECIAL = 2'b00;
  localparam logic [1:0] PID_TYPE_TOKEN   = 2'b01;
  localparam logic [1:0] PID_TYPE_HSK     = 2'b10;
  localparam logic [1:0] PID_TYPE_DATA    = 2'b11;

  // RX_CMD[5:4] value while a packet is being received
  localparam logic [1:0] RX_ACTIVE = 2'b01;

  typedef enum logic [2:0] {
    KIND_NONE,
    KIND_TOKEN,
    KIND_SOF,
    KIND_PING,
    KIND_HANDSHAKE,
    KIND_DATA
  } pkt_kind_e;

  typedef enum logic [1:0] {
    FR_IDLE,
    FR_TURNAROUND,
    FR_ACTIVE
  } framer_state_e;

  typedef struct packed {
    logic      dir;
    logic      nxt;
    usb_byte_t data;
  } ulpi_rx_t;

  typedef struct packed {
    logic      active;
    pkt_kind_e kind;
    usb_pid_t  pid;
    logic      byte_stb;
    usb_byte_t rx_byte;
    logic      rx_end;
  } rx_frame_t;

  typedef struct packed {
    usb_addr_t addr;
    usb_endp_t endp;
    logic      crc5_ok;
  } token_t;

  typedef struct packed {
    logic      valid;
    logic      keep;
    logic      last;
    usb_pid_t  pid;
    usb_byte_t data;
  } stream_t;

  typedef struct packed {
    logic tok_recv;
    logic tok_ping;
    logic sof_recv;
    logic hsk_recv;
    logic data_recv;
    logic crc_valid;
    logic crc_error;
    logic eop;
  } rx_status_t;

  // CRC5 over the 11-bit token field, sent LSB first, result ready to compare
  function automatic crc5_t crc5_calc(input logic [10:0] field);
    crc5_t crc;
    crc = '1;
    for (int i = 0; i < 11; i++) begin
      if (crc[0] ^ field[i]) begin
        crc = (crc >> 1) ^ 5'h14;
      end else begin
        crc = crc >> 1;
      end
    end
    return ~crc;
  endfunction

  // One byte step of CRC16, polynomial 0x8005 reflected
  function automatic crc16_t crc16_next(input crc16_t crc, input usb_byte_t data);
    crc16_t acc;
    acc = crc;
    for (int i = 0; i < 8; i++) begin
      if (acc[0] ^ data[i]) begin
        acc = (acc >> 1) ^ 16'hA001;
      end else begin
        acc = acc >> 1;
      end
    end
    return acc;
  endfunction

endpackage

// File: logic/ulpi_rx_framer.sv
`timescale 1ns/1ps
module ulpi_rx_framer (
  input  logic                  clock,
  input  logic                  reset,
  input  usb_rx_pkg::ulpi_rx_t  ulpi_i,
  output usb_rx_pkg::rx_frame_t frame_o,
  output logic                  idle_o
);

  import usb_rx_pkg::*;

  framer_state_e state_q;
  logic          dir_q;
  logic          xfer;
  logic          pid_ok;
  logic          end_cond;
  usb_pid_t      rx_pid;
  pkt_kind_e     rx_kind;
  pkt_kind_e     kind_q;
  usb_pid_t      pid_q;
  logic          byte_stb_q;
  usb_byte_t     byte_q;
  logic          rx_end_q;

  // A byte moves only when dir has been high for a full cycle and nxt is set
  assign xfer   = ulpi_i.dir && dir_q && ulpi_i.nxt;
  assign rx_pid = ulpi_i.data[3:0];
  assign pid_ok = xfer && (ulpi_i.data[7:4] == ~rx_pid);

  // Dir falling, or an RX_CMD that no longer reports RxActive
  assign end_cond = !ulpi_i.dir ||
                    (dir_q && !ulpi_i.nxt && ulpi_i.data[5:4] != RX_ACTIVE);

  always_comb begin
    case (rx_pid[1:0])
      PID_TYPE_TOKEN:   rx_kind = (rx_pid == PID_SOF) ? KIND_SOF : KIND_TOKEN;
      PID_TYPE_HSK:     rx_kind = KIND_HANDSHAKE;
      PID_TYPE_DATA:    rx_kind = KIND_DATA;
      PID_TYPE_SPECIAL: rx_kind = (rx_pid == PID_PING) ? KIND_PING : KIND_NONE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q    <= FR_IDLE;
      dir_q      <= 1'b0;
      kind_q     <= KIND_NONE;
      byte_stb_q <= 1'b0;
      rx_end_q   <= 1'b0;
    end else begin
      dir_q      <= ulpi_i.dir;
      byte_stb_q <= 1'b0;
      rx_end_q   <= 1'b0;
      case (state_q)
        FR_IDLE: begin
          if (ulpi_i.dir) begin
            state_q <= FR_TURNAROUND;
          end
        end
        FR_TURNAROUND: begin
          // Bytes with a broken PID check are dropped here
          if (!ulpi_i.dir) begin
            state_q <= FR_IDLE;
          end else if (pid_ok) begin
            state_q <= FR_ACTIVE;
            kind_q  <= rx_kind;
          end
        end
        FR_ACTIVE: begin
          // Stay active through the rx_end cycle
          if (rx_end_q) begin
            state_q <= FR_IDLE;
            kind_q  <= KIND_NONE;
          end else if (end_cond) begin
            rx_end_q <= 1'b1;
          end else if (xfer) begin
            byte_stb_q <= 1'b1;
          end
        end
        default: state_q <= FR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == FR_TURNAROUND && pid_ok) begin
      pid_q <= rx_pid;
    end
    if (xfer) begin
      byte_q <= ulpi_i.data;
    end
  end

  assign frame_o = '{
    active:   (state_q == FR_ACTIVE),
    kind:     kind_q,
    pid:      pid_q,
    byte_stb: byte_stb_q,
    rx_byte:  byte_q,
    rx_end:   rx_end_q
  };

  assign idle_o = (state_q != FR_ACTIVE);

  // End of packet is reported inside the packet, then the framer lets go
  assert property (@(posedge clock) disable iff (reset)
    frame_o.rx_end |-> frame_o.active ##1 !frame_o.active);

endmodule

// File: logic/usb_token_parser.sv
`timescale 1ns/1ps
module usb_token_parser (
  input  logic                  clock,
  input  logic                  reset,
  input  usb_rx_pkg::rx_frame_t frame_i,
  output usb_rx_pkg::token_t    token_o
);

  import usb_rx_pkg::*;

  logic [1:0]  cnt_q;
  usb_byte_t   lo_q;
  usb_byte_t   hi_q;
  usb_addr_t   addr_q;
  usb_endp_t   endp_q;
  logic        tok_pkt;
  logic        tok_stb;
  logic [10:0] field;
  crc5_t       rx_crc5;

  // SOF is counted and checked too, only its frame number is not latched
  assign tok_pkt = frame_i.active &&
                   (frame_i.kind inside {KIND_TOKEN, KIND_SOF, KIND_PING});
  assign tok_stb = tok_pkt && frame_i.byte_stb;

  // Token field is {endp, addr}, the CRC sits in the top of the last byte
  assign field   = {hi_q[2:0], lo_q};
  assign rx_crc5 = hi_q[7:3];

  always_ff @(posedge clock) begin
    if (reset || !frame_i.active) begin
      cnt_q <= 2'd0;
    end else if (tok_stb && cnt_q != 2'd3) begin
      cnt_q <= cnt_q + 2'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (tok_stb && cnt_q == 2'd0) begin
      lo_q <= frame_i.rx_byte;
    end
    if (tok_stb && cnt_q == 2'd1) begin
      hi_q <= frame_i.rx_byte;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      addr_q <= '0;
      endp_q <= '0;
    end else if (tok_stb && frame_i.kind != KIND_SOF) begin
      if (cnt_q == 2'd0) begin
        {endp_q[0], addr_q} <= frame_i.rx_byte;
      end else if (cnt_q == 2'd1) begin
        endp_q[3:1] <= frame_i.rx_byte[2:0];
      end
    end
  end

  assign token_o = '{
    addr:    addr_q,
    endp:    endp_q,
    crc5_ok: (cnt_q == 2'd2) && (crc5_calc(field) == rx_crc5)
  };

  // Tokens are PID plus two bytes, nothing more
  assert property (@(posedge clock) disable iff (reset) tok_stb |-> cnt_q < 2'd2);

endmodule

// File: logic/usb_data_pipeline.sv
`timescale 1ns/1ps
module usb_data_pipeline (
  input  logic                  clock,
  input  logic                  reset,
  input  usb_rx_pkg::rx_frame_t frame_i,
  output usb_rx_pkg::stream_t   stream_o,
  output logic                  crc16_ok_o
);

  import usb_rx_pkg::*;

  logic      data_pkt;
  logic      data_stb;
  crc16_t    crc_q;
  logic      s1_vld_q;
  logic      s2_vld_q;
  usb_byte_t s1_dat_q;
  usb_byte_t s2_dat_q;
  logic      valid_q;
  logic      keep_q;
  logic      last_q;
  usb_pid_t  pid_q;
  usb_byte_t dat_q;

  assign data_pkt = frame_i.active && frame_i.kind == KIND_DATA;
  assign data_stb = data_pkt && frame_i.byte_stb;

  // Restarts between packets, CRC bytes are folded in as well
  always_ff @(posedge clock) begin
    if (reset || !frame_i.active) begin
      crc_q <= '1;
    end else if (data_stb) begin
      crc_q <= crc16_next(crc_q, frame_i.rx_byte);
    end
  end

  assign crc16_ok_o = (crc_q == CRC16_RESIDUAL);

  // Two bytes stay behind, at packet end they are the CRC and get dropped
  always_ff @(posedge clock) begin
    if (reset || !data_pkt || frame_i.rx_end) begin
      s1_vld_q <= 1'b0;
      s2_vld_q <= 1'b0;
    end else if (data_stb) begin
      s1_vld_q <= 1'b1;
      s2_vld_q <= s1_vld_q;
    end
  end

  always_ff @(posedge clock) begin
    if (data_stb) begin
      s1_dat_q <= frame_i.rx_byte;
      s2_dat_q <= s1_dat_q;
      dat_q    <= s2_dat_q;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
      keep_q  <= 1'b0;
      last_q  <= 1'b0;
      pid_q   <= PID_NAK;
    end else begin
      valid_q <= data_pkt;
      keep_q  <= data_stb && s2_vld_q;
      last_q  <= data_pkt && frame_i.rx_end;
      if (data_pkt) begin
        pid_q <= frame_i.pid;
      end
    end
  end

  assign stream_o = '{valid: valid_q, keep: keep_q, last: last_q, pid: pid_q, data: dat_q};

  // Payload only travels inside a packet and never on the closing beat
  assert property (@(posedge clock) disable iff (reset)
    stream_o.keep |-> stream_o.valid && !stream_o.last);

endmodule

// File: logic/usb_rx_status.sv
`timescale 1ns/1ps
module usb_rx_status (
  input  logic                    clock,
  input  logic                    reset,
  input  usb_rx_pkg::rx_frame_t   frame_i,
  input  usb_rx_pkg::token_t      token_i,
  input  logic                    crc16_ok_i,
  input  usb_rx_pkg::line_state_t line_state_i,
  output usb_rx_pkg::rx_status_t  status_o
);

  import usb_rx_pkg::*;

  rx_status_t status_q;
  logic       crc_chk;
  logic       crc_ok;
  logic       data_pkt;
  logic       eop_pend_q;
  logic       eop_hit;

  // Pick the check that applies to this kind of packet
  always_comb begin
    case (frame_i.kind)
      KIND_TOKEN, KIND_SOF, KIND_PING: begin
        crc_chk = 1'b1;
        crc_ok  = token_i.crc5_ok;
      end
      KIND_DATA: begin
        crc_chk = 1'b1;
        crc_ok  = crc16_ok_i;
      end
      default: begin
        crc_chk = 1'b0;
        crc_ok  = 1'b0;
      end
    endcase
  end

  // Data EOP fires on SE0 on the line or at rx_end, once per packet
  assign data_pkt = frame_i.active && frame_i.kind == KIND_DATA;
  assign eop_hit  = data_pkt && eop_pend_q &&
                    (frame_i.rx_end || line_state_i == LS_SE0);

  always_ff @(posedge clock) begin
    if (reset || !frame_i.active) begin
      eop_pend_q <= 1'b1;
    end else if (eop_hit) begin
      eop_pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      status_q <= '0;
    end else begin
      status_q <= '0;
      if (frame_i.rx_end) begin
        status_q.tok_recv  <= frame_i.kind == KIND_TOKEN && crc_ok;
        status_q.tok_ping  <= frame_i.kind == KIND_PING && crc_ok;
        status_q.sof_recv  <= frame_i.kind == KIND_SOF && crc_ok;
        status_q.hsk_recv  <= frame_i.kind == KIND_HANDSHAKE;
        status_q.data_recv <= frame_i.kind == KIND_DATA && crc_ok;
        status_q.crc_valid <= crc_chk && crc_ok;
        status_q.crc_error <= crc_chk && !crc_ok;
      end
      status_q.eop <= eop_hit;
    end
  end

  assign status_o = status_q;

  // A failed check never comes with a pass or a receive strobe
  assert property (@(posedge clock) disable iff (reset)
    status_o.crc_error |-> !status_o.crc_valid && !status_o.tok_recv &&
                           !status_o.data_recv && !status_o.sof_recv);

endmodule

// File: logic/ulpi_rx_top.sv
`timescale 1ns/1ps
module ulpi_rx_top (
  input  logic                    clock,
  input  logic                    reset,
  input  usb_rx_pkg::ulpi_rx_t    ulpi_i,
  input  usb_rx_pkg::line_state_t line_state_i,
  output logic                    idle_o,
  output usb_rx_pkg::token_t      token_o,
  output usb_rx_pkg::stream_t     stream_o,
  output usb_rx_pkg::rx_status_t  status_o
);

  import usb_rx_pkg::*;

  rx_frame_t frame;
  token_t    token;
  logic      crc16_ok;

  // Decode the ULPI receive cycle into a framed byte stream
  ulpi_rx_framer i_framer (
    .clock   (clock),
    .reset   (reset),
    .ulpi_i  (ulpi_i),
    .frame_o (frame),
    .idle_o  (idle_o)
  );

  usb_token_parser i_token (
    .clock   (clock),
    .reset   (reset),
    .frame_i (frame),
    .token_o (token)
  );

  usb_data_pipeline i_data (
    .clock      (clock),
    .reset      (reset),
    .frame_i    (frame),
    .stream_o   (stream_o),
    .crc16_ok_o (crc16_ok)
  );

  // Strobes land two cycles after the end of packet on the bus
  usb_rx_status i_status (
    .clock        (clock),
    .reset        (reset),
    .frame_i      (frame),
    .token_i      (token),
    .crc16_ok_i   (crc16_ok),
    .line_state_i (line_state_i),
    .status_o     (status_o)
  );

  assign token_o = token;

endmodule

// File: testbench/ulpi_rx_tb_pkg.svh
`ifndef ULPI_RX_TB_PKG_SVH
`define ULPI_RX_TB_PKG_SVH

localparam usb_pid_t    DATA0_PID    = 4'b0011;
localparam usb_pid_t    DATA1_PID    = 4'b1011;
localparam usb_pid_t    ACK_PID      = 4'b0010;
localparam line_state_t LINE_J       = 2'b01;
// RX_CMD with RxActive set and the line in J
localparam usb_byte_t   RXCMD_ACTIVE = {2'b00, RX_ACTIVE, 4'b0001};

typedef struct packed {
  usb_pid_t   pid;
  usb_addr_t  addr;
  usb_endp_t  endp;
  logic [5:0] len;
  logic       corrupt;
  pkt_kind_e  kind;
} pkt_entry_t;

pkt_entry_t  pkt_table[$];
string       pkt_names[$];
usb_byte_t   tx_bytes[$];
usb_byte_t   exp_payload[$];
int unsigned lcg_state = 79;

function automatic int unsigned lcg_next();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state;
endfunction

task automatic add_entry(input string name, input usb_pid_t pid, input usb_addr_t addr,
                         input usb_endp_t endp, input int len, input logic corrupt,
                         input pkt_kind_e kind);
  pkt_table.push_back('{pid, addr, endp, len[5:0], corrupt, kind});
  pkt_names.push_back(name);
endtask

task automatic load_table();
  add_entry("data0_random", DATA0_PID, 7'h00, 4'h0, 8, 1'b0, KIND_DATA);
  add_entry("out_token", PID_OUT, 7'h05, 4'h1, 0, 1'b0, KIND_TOKEN);
  add_entry("in_token", PID_IN, 7'h2A, 4'hF, 0, 1'b0, KIND_TOKEN);
  add_entry("setup_token", PID_SETUP, 7'h7F, 4'h0, 0, 1'b0, KIND_TOKEN);
  // Frame number bits go in the addr and endp columns
  add_entry("sof_frame", PID_SOF, 7'h33, 4'h5, 0, 1'b0, KIND_SOF);
  add_entry("ping_token", PID_PING, 7'h12, 4'h3, 0, 1'b0, KIND_PING);
  add_entry("ack_handshake", ACK_PID, 7'h00, 4'h0, 0, 1'b0, KIND_HANDSHAKE);
  add_entry("data1_random", DATA1_PID, 7'h00, 4'h0, 20, 1'b0, KIND_DATA);
  add_entry("data0_empty", DATA0_PID, 7'h00, 4'h0, 0, 1'b0, KIND_DATA);
  add_entry("out_bad_crc5", PID_OUT, 7'h44, 4'h2, 0, 1'b1, KIND_TOKEN);
  add_entry("data1_bad_crc16", DATA1_PID, 7'h00, 4'h0, 5, 1'b1, KIND_DATA);
  add_entry("pid_check_fail", DATA0_PID, 7'h00, 4'h0, 2, 1'b0, KIND_NONE);
  add_entry("in_after_fail", PID_IN, 7'h01, 4'h7, 0, 1'b0, KIND_TOKEN);
endtask

// Bytes on the wire for one entry, PID first
task automatic build_packet(input pkt_entry_t e);
  logic [10:0] field;
  crc5_t       crc5;
  crc16_t      crc;
  usb_byte_t   b;
  int unsigned rnd;
  tx_bytes.delete();
  exp_payload.delete();
  if (e.kind == KIND_NONE) begin
    tx_bytes.push_back({e.pid, e.pid});
  end else begin
    tx_bytes.push_back({~e.pid, e.pid});
  end
  case (e.kind)
    KIND_TOKEN, KIND_SOF, KIND_PING: begin
      field = {e.endp, e.addr};
      crc5  = crc5_calc(field);
      b     = {crc5, field[10:8]};
      b[7]  = b[7] ^ e.corrupt;
      tx_bytes.push_back(field[7:0]);
      tx_bytes.push_back(b);
    end
    KIND_DATA: begin
      crc = '1;
      for (int i = 0; i < e.len; i++) begin
        rnd = lcg_next();
        b   = rnd[23:16];
        tx_bytes.push_back(b);
        exp_payload.push_back(b);
        crc = crc16_next(crc, b);
      end
      // CRC field goes out inverted, low byte first
      b    = ~crc[7:0];
      b[0] = b[0] ^ e.corrupt;
      tx_bytes.push_back(b);
      tx_bytes.push_back(~crc[15:8]);
    end
    KIND_NONE: begin
      for (int i = 0; i < e.len; i++) begin
        tx_bytes.push_back(8'h00);
      end
    end
    default: begin
    end
  endcase
endtask

// Turnaround, RX_CMD, bytes with random nxt gaps, then dir drops with SE0
task automatic drive_packet();
  int unsigned rnd;
  @(posedge clock);
  ulpi <= '{dir: 1'b1, nxt: 1'b0, data: 8'h00};
  @(posedge clock);
  ulpi <= '{dir: 1'b1, nxt: 1'b0, data: RXCMD_ACTIVE};
  foreach (tx_bytes[i]) begin
    rnd = lcg_next();
    if (rnd[27:26] == 2'b00) begin
      @(posedge clock);
      ulpi <= '{dir: 1'b1, nxt: 1'b0, data: RXCMD_ACTIVE};
    end
    @(posedge clock);
    ulpi <= '{dir: 1'b1, nxt: 1'b1, data: tx_bytes[i]};
  end
  @(posedge clock);
  ulpi       <= '0;
  line_state <= LS_SE0;
  repeat (2) @(posedge clock);
  line_state <= LINE_J;
endtask

function automatic rx_status_t expected_status(input pkt_entry_t e);
  rx_status_t s;
  s = '0;
  case (e.kind)
    KIND_TOKEN:     s.tok_recv  = !e.corrupt;
    KIND_PING:      s.tok_ping  = !e.corrupt;
    KIND_SOF:       s.sof_recv  = !e.corrupt;
    KIND_HANDSHAKE: s.hsk_recv  = 1'b1;
    KIND_DATA: begin
      s.data_recv = !e.corrupt;
      s.eop       = 1'b1;
    end
    default: begin
    end
  endcase
  if (e.kind inside {KIND_TOKEN, KIND_PING, KIND_SOF, KIND_DATA}) begin
    s.crc_valid = !e.corrupt;
    s.crc_error = e.corrupt;
  end
  return s;
endfunction

task automatic check_byte(input string name, input usb_byte_t exp, input usb_byte_t act);
  if (exp !== act) begin
    mismatch_count++;
    $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic check_pid(input string name, input usb_pid_t exp, input usb_pid_t act);
  if (exp !== act) begin
    mismatch_count++;
    $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic check_token(input string name, input token_t exp, input token_t act);
  if (exp !== act) begin
    mismatch_count++;
    $display("MISMATCH %s: expected addr %h endp %h crc5 %b, actual addr %h endp %h crc5 %b",
             name, exp.addr, exp.endp, exp.crc5_ok, act.addr, act.endp, act.crc5_ok);
  end
endtask

task automatic check_status(input string name, input rx_status_t exp, input rx_status_t act);
  if (exp !== act) begin
    mismatch_count++;
    $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
  end
endtask

task automatic check_count(input string name, input int exp, input int act);
  if (exp != act) begin
    mismatch_count++;
    $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
  end
endtask

`endif

// File: testbench/ulpi_rx_tb.sv
`timescale 1ns/1ps
module ulpi_rx_tb;

  import usb_rx_pkg::*;

  localparam int WAIT_LIMIT = 50;

  logic        clock;
  logic        reset;
  ulpi_rx_t    ulpi;
  line_state_t line_state;
  logic        idle;
  token_t      token;
  stream_t     stream;
  rx_status_t  status;

  int          mismatch_count;
  int          fail_count;
  rx_status_t  status_seen;
  usb_byte_t   beat_data[$];
  usb_pid_t    beat_pid[$];
  int          last_count;
  int          eop_count;
  int          valid_seen;
  int          busy_seen;
  logic        crc5_seen;
  token_t      model_token;

  `include "ulpi_rx_tb_pkg.svh"

  ulpi_rx_top i_dut (
    .clock        (clock),
    .reset        (reset),
    .ulpi_i       (ulpi),
    .line_state_i (line_state),
    .idle_o       (idle),
    .token_o      (token),
    .stream_o     (stream),
    .status_o     (status)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Gather what the DUT reports for the packet in flight
  always @(negedge clock) begin
    if (!reset) begin
      status_seen = status_seen | status;
      if (stream.valid) begin
        valid_seen = 1;
      end
      if (stream.valid && stream.keep) begin
        beat_data.push_back(stream.data);
        beat_pid.push_back(stream.pid);
      end
      if (stream.last) begin
        last_count++;
      end
      // EOP may only pulse once per packet
      if (status.eop) begin
        eop_count++;
      end
      if (token.crc5_ok) begin
        crc5_seen = 1'b1;
      end
      if (!idle) begin
        busy_seen = 1;
      end
    end
  end

  task automatic clear_monitors();
    status_seen = '0;
    beat_data.delete();
    beat_pid.delete();
    last_count = 0;
    eop_count  = 0;
    valid_seen = 0;
    busy_seen  = 0;
    crc5_seen  = 1'b0;
  endtask

  task automatic wait_idle(input string name);
    int count;
    count = 0;
    @(negedge clock);
    while (!idle && count < WAIT_LIMIT) begin
      @(negedge clock);
      count++;
    end
    if (!idle) begin
      fail_count++;
      $display("ERROR %s: receiver did not return to idle in time", name);
    end
  endtask

  // A packet with no expected strobe simply watches the whole window
  task automatic wait_status(input string name, input logic expect_any);
    int count;
    count = 0;
    while (status_seen == '0 && count < WAIT_LIMIT) begin
      @(negedge clock);
      count++;
    end
    if (expect_any && status_seen == '0) begin
      fail_count++;
      $display("ERROR %s: no status strobe arrived before the timeout", name);
    end
    repeat (3) @(negedge clock);
  endtask

  task automatic check_results(input string name, input pkt_entry_t e,
                               input rx_status_t exp_status);
    token_t act_token;
    if (e.kind inside {KIND_TOKEN, KIND_PING}) begin
      model_token.addr = e.addr;
      model_token.endp = e.endp;
    end
    // Every intact token, SOF or PING shows a good CRC5 before it ends
    model_token.crc5_ok = (e.kind inside {KIND_TOKEN, KIND_SOF, KIND_PING}) && !e.corrupt;
    act_token           = token;
    act_token.crc5_ok   = crc5_seen;
    check_status({name, " status"}, exp_status, status_seen);
    check_token({name, " token"}, model_token, act_token);
    check_count({name, " payload beats"}, exp_payload.size(), beat_data.size());
    foreach (beat_data[j]) begin
      if (j < exp_payload.size()) begin
        check_byte($sformatf("%s byte %0d", name, j), exp_payload[j], beat_data[j]);
        check_pid($sformatf("%s pid %0d", name, j), e.pid, beat_pid[j]);
      end
    end
    check_count({name, " last beats"}, e.kind == KIND_DATA, last_count);
    check_count({name, " eop pulses"}, e.kind == KIND_DATA, eop_count);
    check_count({name, " stream valid"}, e.kind == KIND_DATA, valid_seen);
    check_count({name, " left idle"}, e.kind != KIND_NONE, busy_seen);
  endtask

  initial begin
    pkt_entry_t entry;
    string      name;
    rx_status_t exp_status;
    ulpi           = '0;
    line_state     = LINE_J;
    reset          = 1'b1;
    mismatch_count = 0;
    fail_count     = 0;
    model_token    = '0;
    clear_monitors();
    load_table();
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_status("after_reset", '0, status);
    check_pid("after_reset stream pid", PID_NAK, stream.pid);
    check_count("after_reset idle", 1, idle);

    foreach (pkt_table[i]) begin
      entry      = pkt_table[i];
      name       = pkt_names[i];
      build_packet(entry);
      exp_status = expected_status(entry);
      clear_monitors();
      drive_packet();
      wait_idle(name);
      wait_status(name, exp_status != '0);
      check_results(name, entry, exp_status);
    end

    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: ulpi_rx_top.f
+incdir+testbench
logic/usb_rx_pkg.sv
logic/ulpi_rx_framer.sv
logic/usb_token_parser.sv
logic/usb_data_pipeline.sv
logic/usb_rx_status.sv
logic/ulpi_rx_top.sv
testbench/ulpi_rx_tb.sv

// File: Bender.yml
package:
  name: ulpi_rx

sources:
  - logic/usb_rx_pkg.sv
  - logic/ulpi_rx_framer.sv
  - logic/usb_token_parser.sv
  - logic/usb_data_pipeline.sv
  - logic/usb_rx_status.sv
  - logic/ulpi_rx_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/ulpi_rx_tb.sv
